//--- design/cfg_collect_pkg.sv
// ------------------------------
// Widths, sizes and encodings shared by the config collector
// FIFO_DEPTH must be a power of two
// ------------------------------
`default_nettype none

package cfg_collect_pkg;

    // Response word and offset
    localparam int WORD_W   = 32;
    localparam int OFFSET_W = 16;
    localparam int CMD_W    = 2;

    // One record is SEQ_LEN words, one per slot
    localparam int SEQ_LEN = 8;
    localparam int SLOT_W  = 3;

    // Record storage
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    // Narrow fields
    localparam int FLAGS_W = 5;
    localparam int GRAN_W  = 31;

    // Packed record: flags, five wide words, granularity, direction, cmd
    localparam int REC_W = FLAGS_W + 5 * WORD_W + GRAN_W + 1 + CMD_W;

    typedef enum logic [CMD_W-1:0] {
        CMD_INVALID     = 2'd0,
        CMD_MEM_READ    = 2'd1,
        CMD_MEM_WRITE   = 2'd2,
        CMD_MEM_PROGRAM = 2'd3
    } mem_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_COLLECT = 2'd1,
        ST_EMIT    = 2'd2
    } collect_state_t;

    // Slot index doubles as the field opcode
    typedef enum logic [SLOT_W-1:0] {
        SLOT_FLAGS       = 3'd0,
        SLOT_INDEX_START = 3'd1,
        SLOT_INDEX_END   = 3'd2,
        SLOT_STRIDE      = 3'd3,
        SLOT_GRANULARITY = 3'd4,
        SLOT_CMD         = 3'd5,
        SLOT_ARRAY_SIZE  = 3'd6,
        SLOT_CONST_VALUE = 3'd7
    } cfg_slot_t;

endpackage : cfg_collect_pkg

`default_nettype wire

//--- design/program_word_filter.sv
// ------------------------------
// Offsets arrive as word indices, no address shift
// Window is SEQ_BASE up to SEQ_BASE + SEQ_LEN - 1, no wrap past the top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module program_word_filter
    import cfg_collect_pkg::*;
#(
    parameter logic [OFFSET_W-1:0] SEQ_BASE = '0
) (
    input  logic                ap_clk,
    input  logic                rst_n,
    input  logic                resp_valid,
    input  mem_cmd_t            resp_cmd,
    input  logic [OFFSET_W-1:0] resp_offset,
    input  logic [WORD_W-1:0]   resp_data,
    output logic                word_hit,
    output logic                word_at_base,
    output logic [WORD_W-1:0]   word_data
);

    // One extra bit so a window near the top of the range does not overflow
    logic [OFFSET_W:0] offset_ext;
    logic [OFFSET_W:0] win_lo;
    logic [OFFSET_W:0] win_hi;
    logic              in_window;

    assign offset_ext = {1'b0, resp_offset};
    assign win_lo     = {1'b0, SEQ_BASE};
    assign win_hi     = win_lo + (OFFSET_W+1)'(SEQ_LEN);
    assign in_window  = (offset_ext >= win_lo) && (offset_ext < win_hi);

    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            word_hit     <= 1'b0;
            word_at_base <= 1'b0;
        end else begin
            word_hit     <= resp_valid && (resp_cmd == CMD_MEM_PROGRAM) && in_window;
            word_at_base <= (resp_offset == SEQ_BASE);
        end
    end

    always_ff @(posedge ap_clk) begin
        word_data <= resp_data;
    end

endmodule : program_word_filter

`default_nettype wire

//--- design/collect_fsm.sv
// ------------------------------
// A record starts only on a hit at the window base
// Hits seen while waiting to emit are dropped
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module collect_fsm
    import cfg_collect_pkg::*;
(
    input  logic ap_clk,
    input  logic rst_n,
    input  logic word_hit,
    input  logic word_at_base,
    input  logic last_slot,
    input  logic full,
    output logic capture,
    output logic push
);

    collect_state_t state;
    collect_state_t state_nxt;

    // Capture is same-cycle with the hit
    always_comb begin
        capture = 1'b0;
        push    = 1'b0;
        case (state)
            ST_IDLE:    capture = word_hit && word_at_base;
            ST_COLLECT: capture = word_hit;
            ST_EMIT:    push    = !full;
            default:    capture = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (capture) begin
                    state_nxt = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (capture && last_slot) begin
                    state_nxt = ST_EMIT;
                end
            end
            ST_EMIT: begin
                // Hold here until the FIFO has room
                if (push) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule : collect_fsm

`default_nettype wire

//--- design/slot_counter.sv
// ------------------------------
// Position of the next word within a record
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module slot_counter
    import cfg_collect_pkg::*;
(
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              capture,
    input  logic              clear,
    output logic [SLOT_W-1:0] slot,
    output logic              last_slot
);

    assign last_slot = (slot == SLOT_W'(SEQ_LEN - 1));

    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (clear) begin
            slot <= '0;
        end else if (capture) begin
            // Wraps back to slot 0 after the last word
            slot <= slot + 1'b1;
        end
    end

endmodule : slot_counter

`default_nettype wire

//--- design/record_assembler.sv
// ------------------------------
// Fields keep their value until their slot is written again
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module record_assembler
    import cfg_collect_pkg::*;
(
    input  logic               ap_clk,
    input  logic               rst_n,
    input  logic               capture,
    input  cfg_slot_t          slot,
    input  logic [WORD_W-1:0]  word_data,
    output logic [FLAGS_W-1:0] flags,
    output logic [WORD_W-1:0]  index_start,
    output logic [WORD_W-1:0]  index_end,
    output logic [WORD_W-1:0]  stride,
    output logic [GRAN_W-1:0]  granularity,
    output logic               direction,
    output mem_cmd_t           cmd,
    output logic [WORD_W-1:0]  array_size,
    output logic [WORD_W-1:0]  const_value
);

    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            flags       <= '0;
            index_start <= '0;
            index_end   <= '0;
            stride      <= '0;
            granularity <= '0;
            direction   <= 1'b0;
            cmd         <= CMD_INVALID;
            array_size  <= '0;
            const_value <= '0;
        end else if (capture) begin
            case (slot)
                // Bits 0 to 4 hold increment, decrement, mode seq, mode buffer, mode counter
                SLOT_FLAGS:       flags       <= word_data[FLAGS_W-1:0];
                SLOT_INDEX_START: index_start <= word_data;
                SLOT_INDEX_END:   index_end   <= word_data;
                SLOT_STRIDE:      stride      <= word_data;
                SLOT_GRANULARITY: begin
                    granularity <= word_data[GRAN_W-1:0];
                    direction   <= word_data[WORD_W-1];
                end
                SLOT_CMD:         cmd         <= mem_cmd_t'(word_data[CMD_W-1:0]);
                SLOT_ARRAY_SIZE:  array_size  <= word_data;
                SLOT_CONST_VALUE: const_value <= word_data;
            endcase
        end
    end

endmodule : record_assembler

`default_nettype wire

//--- design/cfg_record_fifo.sv
// ------------------------------
// Fall-through head, valid when not_empty is high
// Head fields are undefined while empty
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_record_fifo
    import cfg_collect_pkg::*;
(
    input  logic               ap_clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic               pop,
    input  logic [FLAGS_W-1:0] rec_flags,
    input  logic [WORD_W-1:0]  rec_index_start,
    input  logic [WORD_W-1:0]  rec_index_end,
    input  logic [WORD_W-1:0]  rec_stride,
    input  logic [GRAN_W-1:0]  rec_granularity,
    input  logic               rec_direction,
    input  mem_cmd_t           rec_cmd,
    input  logic [WORD_W-1:0]  rec_array_size,
    input  logic [WORD_W-1:0]  rec_const_value,
    output logic [FLAGS_W-1:0] head_flags,
    output logic [WORD_W-1:0]  head_index_start,
    output logic [WORD_W-1:0]  head_index_end,
    output logic [WORD_W-1:0]  head_stride,
    output logic [GRAN_W-1:0]  head_granularity,
    output logic               head_direction,
    output mem_cmd_t           head_cmd,
    output logic [WORD_W-1:0]  head_array_size,
    output logic [WORD_W-1:0]  head_const_value,
    output logic               not_empty,
    output logic               full
);

    logic [REC_W-1:0] mem [FIFO_DEPTH];
    logic [REC_W-1:0] wr_rec;
    logic [REC_W-1:0] head_rec;
    logic [CMD_W-1:0] head_cmd_bits;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign not_empty = (count != '0);
    assign full      = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign wr_en     = push && !full;
    assign rd_en     = pop && not_empty;

    // ------------------------------
    // Pack and unpack
    // ------------------------------
    assign wr_rec = {rec_flags, rec_index_start, rec_index_end, rec_stride, rec_granularity,
                     rec_direction, rec_cmd, rec_array_size, rec_const_value};

    assign head_rec = mem[rd_ptr];
    assign {head_flags, head_index_start, head_index_end, head_stride, head_granularity,
            head_direction, head_cmd_bits, head_array_size, head_const_value} = head_rec;
    assign head_cmd = mem_cmd_t'(head_cmd_bits);

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    // Pointers wrap naturally with a power-of-two depth
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : cfg_record_fifo

`default_nettype wire

//--- design/cfg_collector_top.sv
// ------------------------------
// Config collector for one engine
// cfg_rd pops the head while cfg_valid is high, otherwise ignored
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_collector_top
    import cfg_collect_pkg::*;
#(
    parameter logic [OFFSET_W-1:0] SEQ_BASE = '0
) (
    input  logic                ap_clk,
    input  logic                rst_n,
    input  logic                resp_valid,
    input  mem_cmd_t            resp_cmd,
    input  logic [OFFSET_W-1:0] resp_offset,
    input  logic [WORD_W-1:0]   resp_data,
    input  logic                cfg_rd,
    output logic                cfg_valid,
    output logic                cfg_full,
    output logic [FLAGS_W-1:0]  cfg_flags,
    output logic [WORD_W-1:0]   cfg_index_start,
    output logic [WORD_W-1:0]   cfg_index_end,
    output logic [WORD_W-1:0]   cfg_stride,
    output logic [GRAN_W-1:0]   cfg_granularity,
    output logic                cfg_direction,
    output mem_cmd_t            cfg_cmd,
    output logic [WORD_W-1:0]   cfg_array_size,
    output logic [WORD_W-1:0]   cfg_const_value
);

    logic               word_hit;
    logic               word_at_base;
    logic [WORD_W-1:0]  word_data;
    logic [SLOT_W-1:0]  slot;
    logic               last_slot;
    logic               capture;
    logic               push;
    logic               full;
    logic [FLAGS_W-1:0] rec_flags;
    logic [WORD_W-1:0]  rec_index_start;
    logic [WORD_W-1:0]  rec_index_end;
    logic [WORD_W-1:0]  rec_stride;
    logic [GRAN_W-1:0]  rec_granularity;
    logic               rec_direction;
    mem_cmd_t           rec_cmd;
    logic [WORD_W-1:0]  rec_array_size;
    logic [WORD_W-1:0]  rec_const_value;

    program_word_filter #(
        .SEQ_BASE(SEQ_BASE)
    ) u_filter (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .resp_valid  (resp_valid),
        .resp_cmd    (resp_cmd),
        .resp_offset (resp_offset),
        .resp_data   (resp_data),
        .word_hit    (word_hit),
        .word_at_base(word_at_base),
        .word_data   (word_data)
    );

    collect_fsm u_fsm (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .word_hit    (word_hit),
        .word_at_base(word_at_base),
        .last_slot   (last_slot),
        .full        (full),
        .capture     (capture),
        .push        (push)
    );

    // Counter restarts once the record leaves for the FIFO
    slot_counter u_slot_counter (
        .ap_clk   (ap_clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .clear    (push),
        .slot     (slot),
        .last_slot(last_slot)
    );

    record_assembler u_assembler (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .slot       (cfg_slot_t'(slot)),
        .word_data  (word_data),
        .flags      (rec_flags),
        .index_start(rec_index_start),
        .index_end  (rec_index_end),
        .stride     (rec_stride),
        .granularity(rec_granularity),
        .direction  (rec_direction),
        .cmd        (rec_cmd),
        .array_size (rec_array_size),
        .const_value(rec_const_value)
    );

    cfg_record_fifo u_fifo (
        .ap_clk          (ap_clk),
        .rst_n           (rst_n),
        .push            (push),
        .pop             (cfg_rd),
        .rec_flags       (rec_flags),
        .rec_index_start (rec_index_start),
        .rec_index_end   (rec_index_end),
        .rec_stride      (rec_stride),
        .rec_granularity (rec_granularity),
        .rec_direction   (rec_direction),
        .rec_cmd         (rec_cmd),
        .rec_array_size  (rec_array_size),
        .rec_const_value (rec_const_value),
        .head_flags      (cfg_flags),
        .head_index_start(cfg_index_start),
        .head_index_end  (cfg_index_end),
        .head_stride     (cfg_stride),
        .head_granularity(cfg_granularity),
        .head_direction  (cfg_direction),
        .head_cmd        (cfg_cmd),
        .head_array_size (cfg_array_size),
        .head_const_value(cfg_const_value),
        .not_empty       (cfg_valid),
        .full            (full)
    );

    assign cfg_full = full;

endmodule : cfg_collector_top

`default_nettype wire

//--- dv/cfg_collector_assertions.sv
// ------------------------------
// Protocol checks bound into cfg_collector_top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_collector_assertions (
    input logic ap_clk,
    input logic rst_n,
    input logic push,
    input logic full,
    input logic capture,
    input logic word_hit,
    input logic cfg_valid
);

    // FIFO never written while full
    a_no_push_full: assert property (@(posedge ap_clk) disable iff (!rst_n) !(push && full))
        else $error("push raised while the record FIFO is full");

    a_capture_hit: assert property (@(posedge ap_clk) disable iff (!rst_n) capture |-> word_hit)
        else $error("capture raised without word_hit");

    a_reset_empty: assert property (@(posedge ap_clk) !rst_n |-> !cfg_valid)
        else $error("cfg_valid high during reset");

endmodule : cfg_collector_assertions

bind cfg_collector_top cfg_collector_assertions u_assertions (
    .ap_clk   (ap_clk),
    .rst_n    (rst_n),
    .push     (push),
    .full     (full),
    .capture  (capture),
    .word_hit (word_hit),
    .cfg_valid(cfg_valid)
);

`default_nettype wire

//--- dv/tb_cfg_collector.sv
// ------------------------------
// Testbench for cfg_collector_top with SEQ_BASE 16
// The fifth back-pressure record is held in the FSM; the sixth is dropped
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_collector
    import cfg_collect_pkg::*;
();

    localparam logic [OFFSET_W-1:0] BASE = 16'd16;

    logic                ap_clk;
    logic                rst_n;
    logic                resp_valid;
    mem_cmd_t            resp_cmd;
    logic [OFFSET_W-1:0] resp_offset;
    logic [WORD_W-1:0]   resp_data;
    logic                cfg_rd;
    logic                cfg_valid;
    logic                cfg_full;
    logic [FLAGS_W-1:0]  cfg_flags;
    logic [WORD_W-1:0]   cfg_index_start;
    logic [WORD_W-1:0]   cfg_index_end;
    logic [WORD_W-1:0]   cfg_stride;
    logic [GRAN_W-1:0]   cfg_granularity;
    logic                cfg_direction;
    mem_cmd_t            cfg_cmd;
    logic [WORD_W-1:0]   cfg_array_size;
    logic [WORD_W-1:0]   cfg_const_value;

    logic [REC_W-1:0] exp_q [$];
    logic [31:0]      lcg_state = 32'd8;
    logic             pop_en = 1'b0;

    cfg_collector_top #(
        .SEQ_BASE(BASE)
    ) UUT (
        .ap_clk         (ap_clk),
        .rst_n          (rst_n),
        .resp_valid     (resp_valid),
        .resp_cmd       (resp_cmd),
        .resp_offset    (resp_offset),
        .resp_data      (resp_data),
        .cfg_rd         (cfg_rd),
        .cfg_valid      (cfg_valid),
        .cfg_full       (cfg_full),
        .cfg_flags      (cfg_flags),
        .cfg_index_start(cfg_index_start),
        .cfg_index_end  (cfg_index_end),
        .cfg_stride     (cfg_stride),
        .cfg_granularity(cfg_granularity),
        .cfg_direction  (cfg_direction),
        .cfg_cmd        (cfg_cmd),
        .cfg_array_size (cfg_array_size),
        .cfg_const_value(cfg_const_value)
    );

    always #4 ap_clk = ~ap_clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Field layout: flags, index start/end, stride, granularity, dir, cmd, size, const
    function automatic logic [REC_W-1:0] expected_record(input logic [7:0][31:0] w);
        logic [FLAGS_W-1:0] flags;
        logic [GRAN_W-1:0]  gran;
        logic               dir;
        logic [1:0]         cmd;
        flags = w[0][FLAGS_W-1:0];
        gran  = w[4][GRAN_W-1:0];
        dir   = w[4][31];
        cmd   = w[5][1:0];
        return {flags, w[1], w[2], w[3], gran, dir, cmd, w[6], w[7]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("ERR %s expected %h actual %h", name, exp_v, act_v);
        $display("Simulation failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic drive_word(input mem_cmd_t cmd, input logic [OFFSET_W-1:0] offset,
                              input logic [WORD_W-1:0] data);
        @(posedge ap_clk);
        #1;
        resp_valid  = 1'b1;
        resp_cmd    = cmd;
        resp_offset = offset;
        resp_data   = data;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ap_clk);
            #1;
            resp_valid = 1'b0;
        end
    endtask

    task automatic build_words(output logic [7:0][31:0] w);
        for (int i = 0; i < SEQ_LEN; i++) begin
            w[i] = next_rand();
        end
    endtask

    // Optional junk: a non-program word in the window, program words above and below it
    task automatic send_sequence(input logic [7:0][31:0] w, input bit with_junk);
        for (int i = 0; i < SEQ_LEN; i++) begin
            drive_word(CMD_MEM_PROGRAM, OFFSET_W'(BASE + i), w[i]);
            if (with_junk) begin
                drive_word(CMD_MEM_WRITE, OFFSET_W'(BASE + i), ~w[i]);
                drive_word(CMD_MEM_PROGRAM, OFFSET_W'(BASE + SEQ_LEN + i), ~w[i]);
                drive_word(CMD_MEM_PROGRAM, BASE - 16'd1, w[i] ^ 32'h5a5a_5a5a);
            end
        end
        idle_cycles(2);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge ap_clk);
            n++;
        end
        if (exp_q.size() != 0) abort_run("Timed out waiting for expected records");
    endtask

    task automatic wait_for_full(input int limit);
        int n;
        n = 0;
        while (!cfg_full && n < limit) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        if (!cfg_full) abort_run("Timed out waiting for cfg_full");
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------
    initial begin : compare_proc
        logic [FLAGS_W-1:0] e_flags;
        logic [WORD_W-1:0]  e_start;
        logic [WORD_W-1:0]  e_end;
        logic [WORD_W-1:0]  e_stride;
        logic [GRAN_W-1:0]  e_gran;
        logic               e_dir;
        logic [1:0]         e_cmd;
        logic [WORD_W-1:0]  e_size;
        logic [WORD_W-1:0]  e_const;
        cfg_rd = 1'b0;
        forever begin
            @(posedge ap_clk);
            #1;
            cfg_rd = 1'b0;
            if (pop_en && cfg_valid) begin
                assert (exp_q.size() != 0) else abort_run("Record appeared with none expected");
                {e_flags, e_start, e_end, e_stride, e_gran, e_dir, e_cmd, e_size, e_const} =
                    exp_q.pop_front();
                assert (cfg_flags == e_flags)
                    else report_mismatch("cfg_flags", 32'(e_flags), 32'(cfg_flags));
                assert (cfg_index_start == e_start)
                    else report_mismatch("cfg_index_start", e_start, cfg_index_start);
                assert (cfg_index_end == e_end)
                    else report_mismatch("cfg_index_end", e_end, cfg_index_end);
                assert (cfg_stride == e_stride)
                    else report_mismatch("cfg_stride", e_stride, cfg_stride);
                assert (cfg_granularity == e_gran)
                    else report_mismatch("cfg_granularity", 32'(e_gran), 32'(cfg_granularity));
                assert (cfg_direction == e_dir)
                    else report_mismatch("cfg_direction", 32'(e_dir), 32'(cfg_direction));
                assert (cfg_cmd == e_cmd)
                    else report_mismatch("cfg_cmd", 32'(e_cmd), 32'(cfg_cmd));
                assert (cfg_array_size == e_size)
                    else report_mismatch("cfg_array_size", e_size, cfg_array_size);
                assert (cfg_const_value == e_const)
                    else report_mismatch("cfg_const_value", e_const, cfg_const_value);
                cfg_rd = 1'b1;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin : main_seq
        logic [7:0][31:0] w;
        ap_clk      = 1'b0;
        rst_n       = 1'b0;
        resp_valid  = 1'b0;
        resp_cmd    = CMD_INVALID;
        resp_offset = '0;
        resp_data   = '0;
        repeat (4) @(posedge ap_clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        @(posedge ap_clk);
        #1;
        assert (!cfg_valid) else report_mismatch("cfg_valid", 32'd0, 32'(cfg_valid));
        assert (!cfg_full) else report_mismatch("cfg_full", 32'd0, 32'(cfg_full));
        pop_en = 1'b1;

        // Single record
        build_words(w);
        exp_q.push_back(expected_record(w));
        send_sequence(w, 1'b0);
        wait_drained(100);

        // Junk interleaved during collection
        build_words(w);
        exp_q.push_back(expected_record(w));
        send_sequence(w, 1'b1);
        wait_drained(100);

        // In-window word off the base while idle starts nothing
        drive_word(CMD_MEM_PROGRAM, BASE + 16'd3, next_rand());
        idle_cycles(3);
        build_words(w);
        exp_q.push_back(expected_record(w));
        send_sequence(w, 1'b0);
        wait_drained(100);

        // Back-pressure with no popping
        pop_en = 1'b0;
        for (int s = 0; s < 4; s++) begin
            if (s == 3) begin
                assert (!cfg_full) else report_mismatch("cfg_full", 32'd0, 32'(cfg_full));
            end
            build_words(w);
            exp_q.push_back(expected_record(w));
            send_sequence(w, 1'b0);
        end
        wait_for_full(50);
        // Fifth record waits in the FSM, sixth arrives during the wait
        build_words(w);
        exp_q.push_back(expected_record(w));
        send_sequence(w, 1'b0);
        build_words(w);
        send_sequence(w, 1'b0);
        assert (cfg_full) else report_mismatch("cfg_full", 32'd1, 32'(cfg_full));
        pop_en = 1'b1;
        wait_drained(200);
        idle_cycles(20);

        if (exp_q.size() == 0 && !cfg_valid) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("Records left over at the end of the run");
        end
    end

endmodule : tb_cfg_collector

`default_nettype wire

//--- all.f
design/cfg_collect_pkg.sv
design/program_word_filter.sv
design/collect_fsm.sv
design/slot_counter.sv
design/record_assembler.sv
design/cfg_record_fifo.sv
design/cfg_collector_top.sv
dv/cfg_collector_assertions.sv
dv/tb_cfg_collector.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the config collector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cfg_collector -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulator output"
exit 1
